// File: hdl/spi_cmd_pkg.sv
package spi_cmd_pkg;

  ////////////////////
  // Command opcodes
  ////////////////////

  // First byte of every message
  typedef enum logic [7:0] {
    SET_ADDR   = 8'h01,
    WRITE_MEM  = 8'h02,
    READ_MEM   = 8'h03,
    GET_STATUS = 8'h04
  } cmd_op_e;

  // Controller states
  typedef enum logic [2:0] {
    IDLE,
    ADDR_HI,
    ADDR_LO,
    WRITE,
    READ,
    STATUS,
    IGNORE
  } cmd_state_e;

  // Default RAM address width, 1024 bytes
  localparam int DEF_ADDR_W = 10;
  // Default per-message byte counter width, saturating
  localparam int DEF_CNT_W  = 8;

endpackage

// File: hdl/spi_byte_if.sv
`timescale 1ns/1ps

interface spi_byte_if #(
  parameter int CNT_W = spi_cmd_pkg::DEF_CNT_W
);
  // Byte strobes, one clk wide
  logic             cmd_ready;
  logic             param_ready;
  // Received byte, valid with either strobe
  logic [7:0]       rx_data;
  // Bytes seen in this message
  logic [CNT_W-1:0] byte_cnt;
  // Select edges after synchronization
  logic             start_msg;
  logic             end_msg;
  // Reply byte, held as a level
  logic [7:0]       tx_data;

  modport slave (output cmd_ready, param_ready, rx_data, byte_cnt,
                 output start_msg, end_msg, input tx_data);
  modport ctrl  (input cmd_ready, param_ready, rx_data, byte_cnt,
                 input start_msg, end_msg, output tx_data);

endinterface

// File: hdl/spi_slave.sv
`timescale 1ns/1ps

module spi_slave #(
  parameter int CNT_W = spi_cmd_pkg::DEF_CNT_W
) (
  input  logic      clk,
  input  logic      arst_n,
  input  logic      sck,
  input  logic      mosi,
  input  logic      ssel_n,
  output logic      miso,
  output logic      miso_oe,
  spi_byte_if.slave bus
);

  ////////////////////
  // SCK domain
  ////////////////////

  logic [2:0] ssel_sck_q;
  logic [2:0] bit_cnt;
  logic [7:0] shift_q;

  // Select as seen by SCK
  always_ff @(posedge sck or negedge arst_n) begin
    if (!arst_n) begin
      ssel_sck_q <= '0;
    end else begin
      ssel_sck_q <= {ssel_sck_q[1:0], ssel_n};
    end
  end

  // Bit position in current byte, wraps after 8
  always_ff @(posedge sck or negedge arst_n) begin
    if (!arst_n) begin
      bit_cnt <= '0;
    end else if (ssel_sck_q[2]) begin
      bit_cnt <= '0;
    end else begin
      bit_cnt <= bit_cnt + 3'd1;
    end
  end

  // MSB first into the shifter
  always_ff @(posedge sck or negedge arst_n) begin
    if (!arst_n) begin
      shift_q <= '0;
    end else if (!ssel_sck_q[2]) begin
      shift_q <= {shift_q[6:0], mosi};
    end
  end

  ////////////////////
  // CLK domain
  ////////////////////

  logic [2:0]       ssel_q;
  logic [2:0]       wrap_q;
  logic             byte_sync;
  logic             sel_active;
  logic [CNT_W-1:0] byte_cnt_q;
  logic             cmd_pre_q;
  logic             par_pre_q;
  logic             cmd_q;
  logic             par_q;
  logic [7:0]       rx_q;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      ssel_q <= 3'b111;
      wrap_q <= '0;
    end else begin
      ssel_q <= {ssel_q[1:0], ssel_n};
      // Counter MSB falls when a byte completes
      wrap_q <= {wrap_q[1:0], bit_cnt[2]};
    end
  end

  assign sel_active = ~ssel_q[1];
  assign byte_sync  = (wrap_q[2:1] == 2'b10);

  // Saturating byte count, cleared between messages
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      byte_cnt_q <= '0;
    end else if (!sel_active) begin
      byte_cnt_q <= '0;
    end else if (byte_sync && byte_cnt_q != '1) begin
      byte_cnt_q <= byte_cnt_q + 1'b1;
    end
  end

  // Strobe pipeline, decision uses count before increment
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      cmd_pre_q <= 1'b0;
      par_pre_q <= 1'b0;
      cmd_q     <= 1'b0;
      par_q     <= 1'b0;
    end else begin
      cmd_pre_q <= byte_sync && (byte_cnt_q == '0);
      par_pre_q <= byte_sync && (byte_cnt_q != '0);
      cmd_q     <= cmd_pre_q;
      par_q     <= par_pre_q;
    end
  end

  // Shifter is stable here for many clk cycles
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      rx_q <= '0;
    end else if (cmd_pre_q || par_pre_q) begin
      rx_q <= shift_q;
    end
  end

  assign bus.cmd_ready   = cmd_q;
  assign bus.param_ready = par_q;
  assign bus.rx_data     = rx_q;
  assign bus.byte_cnt    = byte_cnt_q;
  assign bus.start_msg   = (ssel_q[2:1] == 2'b10);
  assign bus.end_msg     = (ssel_q[2:1] == 2'b01);

  // Reply bit, MSB first
  assign miso    = bus.tx_data[3'd7 - bit_cnt];
  assign miso_oe = ~ssel_n;

endmodule

// File: hdl/mcu_cmd.sv
`timescale 1ns/1ps

module mcu_cmd #(
  parameter int ADDR_W = spi_cmd_pkg::DEF_ADDR_W,
  parameter int CNT_W  = spi_cmd_pkg::DEF_CNT_W
) (
  input  logic       clk,
  input  logic       arst_n,
  spi_byte_if.ctrl   bus,
  output logic       load_hi,
  output logic       load_lo,
  output logic       inc,
  output logic [7:0] load_data,
  output logic       we,
  output logic [7:0] wdata,
  input  logic [7:0] rdata
);

  import spi_cmd_pkg::*;

  // High address byte only matters above 256 bytes
  localparam bit HAS_HI = (ADDR_W > 8);

  cmd_state_e state_q;
  cmd_op_e    op;
  logic       cmd_valid;
  logic       msg_edge;
  logic [1:0] pend_q;
  logic [7:0] wr_count_q;
  logic [7:0] tx_q;

  assign op        = cmd_op_e'(bus.rx_data);
  // Command strobe always carries the first byte
  assign cmd_valid = bus.cmd_ready && (bus.byte_cnt == CNT_W'(1));
  assign msg_edge  = bus.start_msg || bus.end_msg;

  ////////////////////
  // State machine
  ////////////////////

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      state_q <= IDLE;
    end else if (msg_edge) begin
      state_q <= IDLE;
    end else if (cmd_valid) begin
      case (op)
        SET_ADDR:   state_q <= ADDR_HI;
        WRITE_MEM:  state_q <= WRITE;
        READ_MEM:   state_q <= READ;
        GET_STATUS: state_q <= STATUS;
        default:    state_q <= IGNORE;
      endcase
    end else if (bus.param_ready) begin
      case (state_q)
        ADDR_HI: state_q <= ADDR_LO;
        ADDR_LO: state_q <= IGNORE;
        STATUS:  state_q <= IGNORE;
        IDLE:    state_q <= IGNORE;
        default: state_q <= state_q;
      endcase
    end
  end

  // Address and write steering, same cycle as the strobe
  assign load_hi   = HAS_HI && (state_q == ADDR_HI) && bus.param_ready;
  assign load_lo   = (state_q == ADDR_LO) && bus.param_ready;
  assign load_data = bus.rx_data;
  assign we        = (state_q == WRITE) && bus.param_ready;
  assign wdata     = bus.rx_data;
  // Post-increment after write or after each read byte
  assign inc       = ((state_q == WRITE) || (state_q == READ)) && bus.param_ready;

  ////////////////////
  // Read prefetch
  ////////////////////

  // 2 cycles: addr settles, then RAM output register
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      pend_q <= '0;
    end else if (msg_edge) begin
      pend_q <= '0;
    end else if ((cmd_valid && op == READ_MEM) ||
                 (state_q == READ && bus.param_ready)) begin
      pend_q <= 2'd2;
    end else if (pend_q != '0) begin
      pend_q <= pend_q - 2'd1;
    end
  end

  // Bytes written since reset, wraps at 256
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      wr_count_q <= '0;
    end else if (we) begin
      wr_count_q <= wr_count_q + 8'd1;
    end
  end

  // Reply byte: RAM data on prefetch, else status count
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      tx_q <= '0;
    end else if (pend_q == 2'd1) begin
      tx_q <= rdata;
    end else if (state_q == IDLE || state_q == STATUS) begin
      tx_q <= wr_count_q;
    end
  end

  assign bus.tx_data = tx_q;

endmodule

// File: hdl/mem_addr_gen.sv
`timescale 1ns/1ps

module mem_addr_gen #(
  parameter int ADDR_W = spi_cmd_pkg::DEF_ADDR_W
) (
  input  logic              clk,
  input  logic              arst_n,
  input  logic              load_hi,
  input  logic              load_lo,
  input  logic              inc,
  input  logic [7:0]        load_data,
  output logic [ADDR_W-1:0] addr
);

  logic [ADDR_W-1:0] addr_q;
  logic [15:0]       addr_ext;

  // Zero-extended view for byte replacement
  assign addr_ext = 16'(addr_q);

  ////////////////////
  // Address register
  ////////////////////

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      addr_q <= '0;
    end else if (load_hi) begin
      // Upper bits beyond ADDR_W drop off
      addr_q <= ADDR_W'({load_data, addr_ext[7:0]});
    end else if (load_lo) begin
      addr_q <= ADDR_W'({addr_ext[15:8], load_data});
    end else if (inc) begin
      // Natural overflow wraps to 0 at top of memory
      addr_q <= addr_q + 1'b1;
    end
  end

  assign addr = addr_q;

endmodule

// File: hdl/data_ram.sv
`timescale 1ns/1ps

module data_ram #(
  parameter int ADDR_W = spi_cmd_pkg::DEF_ADDR_W
) (
  input  logic              clk,
  input  logic              arst_n,
  input  logic              we,
  input  logic [ADDR_W-1:0] addr,
  input  logic [7:0]        wdata,
  output logic [7:0]        rdata
);

  localparam int DEPTH = 2 ** ADDR_W;

  logic [7:0] mem [DEPTH];

  // Write port
  always_ff @(posedge clk) begin
    if (we) begin
      mem[addr] <= wdata;
    end
  end

  // Registered read, one clk behind addr
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      rdata <= '0;
    end else begin
      rdata <= mem[addr];
    end
  end

endmodule

// File: hdl/spi_mem_top.sv
`timescale 1ns/1ps

module spi_mem_top #(
  parameter int ADDR_W = spi_cmd_pkg::DEF_ADDR_W,
  parameter int CNT_W  = spi_cmd_pkg::DEF_CNT_W
) (
  input  logic clk,
  input  logic arst_n,
  input  logic sck,
  input  logic mosi,
  input  logic ssel_n,
  output logic miso,
  output logic miso_oe
);

  ////////////////////
  // Internal wiring
  ////////////////////

  logic              load_hi;
  logic              load_lo;
  logic              inc;
  logic [7:0]        load_data;
  logic              we;
  logic [7:0]        wdata;
  logic [7:0]        rdata;
  logic [ADDR_W-1:0] addr;

  // Receiver to controller
  spi_byte_if #(.CNT_W(CNT_W)) byte_bus ();

  spi_slave #(.CNT_W(CNT_W)) u_slave (
    .clk     (clk),
    .arst_n  (arst_n),
    .sck     (sck),
    .mosi    (mosi),
    .ssel_n  (ssel_n),
    .miso    (miso),
    .miso_oe (miso_oe),
    .bus     (byte_bus.slave)
  );

  mcu_cmd #(.ADDR_W(ADDR_W), .CNT_W(CNT_W)) u_cmd (
    .clk       (clk),
    .arst_n    (arst_n),
    .bus       (byte_bus.ctrl),
    .load_hi   (load_hi),
    .load_lo   (load_lo),
    .inc       (inc),
    .load_data (load_data),
    .we        (we),
    .wdata     (wdata),
    .rdata     (rdata)
  );

  mem_addr_gen #(.ADDR_W(ADDR_W)) u_addr (
    .clk       (clk),
    .arst_n    (arst_n),
    .load_hi   (load_hi),
    .load_lo   (load_lo),
    .inc       (inc),
    .load_data (load_data),
    .addr      (addr)
  );

  data_ram #(.ADDR_W(ADDR_W)) u_ram (
    .clk    (clk),
    .arst_n (arst_n),
    .we     (we),
    .addr   (addr),
    .wdata  (wdata),
    .rdata  (rdata)
  );

endmodule

// File: testbench/tb_spi_mem_sva.sv
`timescale 1ns/1ps

module tb_spi_mem_sva (
  input logic                    clk,
  input logic                    arst_n,
  input logic                    cmd_ready,
  input logic                    param_ready,
  input logic                    we,
  input spi_cmd_pkg::cmd_state_e state,
  input logic                    miso_oe,
  input logic                    ssel_n
);

  import spi_cmd_pkg::*;

  ////////////////////
  // Byte strobes
  ////////////////////

  // Command and parameter strobes never overlap
  a_strobe_excl: assert property (@(posedge clk) disable iff (!arst_n)
    !(cmd_ready && param_ready))
    else $error("cmd_ready and param_ready high together");

  // One clk wide
  a_cmd_pulse: assert property (@(posedge clk) disable iff (!arst_n)
    cmd_ready |=> !cmd_ready)
    else $error("cmd_ready longer than one cycle");

  a_par_pulse: assert property (@(posedge clk) disable iff (!arst_n)
    param_ready |=> !param_ready)
    else $error("param_ready longer than one cycle");

  // Writes only from the WRITE state
  a_we_state: assert property (@(posedge clk) disable iff (!arst_n)
    we |-> (state == WRITE))
    else $error("we high outside WRITE state");

  // Output enable tracks select
  a_miso_oe: assert property (@(posedge clk) disable iff (!arst_n)
    miso_oe == !ssel_n)
    else $error("miso_oe does not follow ssel_n");

endmodule

bind spi_slave tb_spi_mem_sva u_sva_slave (
  .clk         (clk),
  .arst_n      (arst_n),
  .cmd_ready   (cmd_q),
  .param_ready (par_q),
  .we          (1'b0),
  .state       (spi_cmd_pkg::IDLE),
  .miso_oe     (miso_oe),
  .ssel_n      (ssel_n)
);

bind mcu_cmd tb_spi_mem_sva u_sva_cmd (
  .clk         (clk),
  .arst_n      (arst_n),
  .cmd_ready   (1'b0),
  .param_ready (1'b0),
  .we          (we),
  .state       (state_q),
  .miso_oe     (1'b0),
  .ssel_n      (1'b1)
);

// File: testbench/tb_spi_mem.sv
`timescale 1ns/1ps

module tb_spi_mem;

  import spi_cmd_pkg::*;

  localparam int ADDR_W   = 10;
  localparam int CLK_NS   = 4;
  // SCK half-period in clk cycles
  localparam int HALF     = 10;
  // Idle clk cycles between messages
  localparam int GAP      = 12;
  localparam int MAX_PAR  = 8;
  // Longest message: command plus MAX_PAR bytes, select setup and gap
  localparam int MSG_CLKS = (MAX_PAR + 1) * 16 * HALF + 2 * HALF + GAP;
  localparam int MARGIN   = 2000;

  logic clk;
  logic arst_n;
  logic sck;
  logic mosi;
  logic ssel_n;
  logic miso;
  logic miso_oe;

  ////////////////////
  // Message table
  ////////////////////

  logic [7:0]  tab_op[$];
  int          tab_n[$];
  bit          tab_chk[$];
  // Parameter byte k sits in bits 8k+7:8k
  logic [63:0] tab_par[$];

  // Reference model of RAM, address and write count
  logic [7:0]        ref_mem [2**ADDR_W];
  logic [ADDR_W-1:0] m_addr;
  logic [7:0]        m_count;

  logic [31:0] lcg_state;
  int          n_checks;
  int          n_errors;
  // Bytes seen on miso, index 0 is the command byte
  logic [7:0]  rx_bytes [MAX_PAR+1];

  spi_mem_top #(.ADDR_W(ADDR_W)) dut (
    .clk     (clk),
    .arst_n  (arst_n),
    .sck     (sck),
    .mosi    (mosi),
    .ssel_n  (ssel_n),
    .miso    (miso),
    .miso_oe (miso_oe)
  );

  always #(CLK_NS / 2) clk = ~clk;

  // Inputs change just after the rising edge
  task automatic wait_clks(input int n);
    repeat (n) @(posedge clk);
    #0.5;
  endtask

  // LCG step, middle bits give the data byte
  function automatic logic [7:0] next_rand();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return lcg_state[23:16];
  endfunction

  task automatic check(input logic [7:0] act, input logic [7:0] exp, input string what);
    n_checks++;
    if (act !== exp) begin
      n_errors++;
      $display("ERR %0t: %s, expected %02h, got %02h", $time, what, exp, act);
    end
  endtask

  task automatic add_row(input logic [7:0] op, input int n, input bit chk, input bit rnd,
                         input logic [63:0] par);
    logic [63:0] p;
    p = par;
    // Random rows get fresh LCG bytes
    if (rnd) begin
      for (int i = 0; i < n; i++) begin
        p[8*i +: 8] = next_rand();
      end
    end
    tab_op.push_back(op);
    tab_n.push_back(n);
    tab_chk.push_back(chk);
    tab_par.push_back(p);
  endtask

  task automatic build_table();
    // Status straight after reset
    add_row(GET_STATUS, 1, 1'b1, 1'b0, 64'h0);
    // Write and read back at 0x123
    add_row(SET_ADDR,   2, 1'b0, 1'b0, 64'h23_01);
    add_row(WRITE_MEM,  8, 1'b0, 1'b1, 64'h0);
    add_row(SET_ADDR,   2, 1'b0, 1'b0, 64'h23_01);
    add_row(READ_MEM,   8, 1'b1, 1'b0, 64'h0);
    add_row(GET_STATUS, 1, 1'b1, 1'b0, 64'h0);
    // Crosses the top address 0x3FF
    add_row(SET_ADDR,   2, 1'b0, 1'b0, 64'hFE_03);
    add_row(WRITE_MEM,  5, 1'b0, 1'b1, 64'h0);
    add_row(SET_ADDR,   2, 1'b0, 1'b0, 64'hFE_03);
    add_row(READ_MEM,   5, 1'b1, 1'b0, 64'h0);
    // Unknown opcode with data-like bytes over the block at 0x123
    add_row(SET_ADDR,   2, 1'b0, 1'b0, 64'h23_01);
    add_row(8'hA5,      6, 1'b0, 1'b0, 64'h66_55_44_33_22_11);
    add_row(GET_STATUS, 1, 1'b1, 1'b0, 64'h0);
    add_row(SET_ADDR,   2, 1'b0, 1'b0, 64'h23_01);
    add_row(READ_MEM,   8, 1'b1, 1'b0, 64'h0);
    add_row(SET_ADDR,   2, 1'b0, 1'b0, 64'hFE_03);
    add_row(READ_MEM,   5, 1'b1, 1'b0, 64'h0);
    // Second block at 0x200
    add_row(SET_ADDR,   2, 1'b0, 1'b0, 64'h00_02);
    add_row(WRITE_MEM,  8, 1'b0, 1'b1, 64'h0);
    add_row(SET_ADDR,   2, 1'b0, 1'b0, 64'h00_02);
    add_row(READ_MEM,   8, 1'b1, 1'b0, 64'h0);
    add_row(GET_STATUS, 1, 1'b1, 1'b0, 64'h0);
  endtask

  ////////////////////
  // SPI master, mode 0
  ////////////////////

  // MSB first, miso sampled just before the rising sck edge
  task automatic send_byte(input logic [7:0] tx, output logic [7:0] rx);
    for (int i = 7; i >= 0; i--) begin
      mosi = tx[i];
      wait_clks(HALF);
      rx[i] = miso;
      sck = 1'b1;
      wait_clks(HALF);
      sck = 1'b0;
    end
  endtask

  task automatic run_message(input int idx);
    logic [7:0]  rx;
    logic [63:0] par;
    int          n;
    par = tab_par[idx];
    n = tab_n[idx];
    ssel_n = 1'b0;
    wait_clks(HALF);
    check({7'd0, miso_oe}, 8'd1, $sformatf("row %0d miso_oe while selected", idx));
    send_byte(tab_op[idx], rx);
    rx_bytes[0] = rx;
    for (int k = 1; k <= n; k++) begin
      send_byte(par[8*(k-1) +: 8], rx);
      rx_bytes[k] = rx;
    end
    // Let the last strobe land before deselect
    wait_clks(HALF);
    ssel_n = 1'b1;
    wait_clks(GAP);
  endtask

  // Compare replies, then advance the model
  task automatic score_message(input int idx);
    logic [7:0]  op;
    logic [63:0] par;
    int          n;
    op = tab_op[idx];
    par = tab_par[idx];
    n = tab_n[idx];
    // Command byte always carries the status count
    check(rx_bytes[0], m_count, $sformatf("row %0d status on command byte", idx));
    case (op)
      SET_ADDR: begin
        if (n >= 1) begin
          m_addr = ADDR_W'({par[7:0], m_addr[7:0]});
        end
        if (n >= 2) begin
          m_addr = {m_addr[ADDR_W-1:8], par[15:8]};
        end
      end
      WRITE_MEM: begin
        for (int k = 0; k < n; k++) begin
          ref_mem[m_addr] = par[8*k +: 8];
          m_addr = m_addr + ADDR_W'(1);
          m_count = m_count + 8'd1;
        end
      end
      READ_MEM: begin
        for (int k = 0; k < n; k++) begin
          if (tab_chk[idx]) begin
            check(rx_bytes[k+1], ref_mem[m_addr],
                  $sformatf("row %0d read byte %0d at %03h", idx, k + 1, m_addr));
          end
          m_addr = m_addr + ADDR_W'(1);
        end
      end
      GET_STATUS: begin
        if (tab_chk[idx] && n >= 1) begin
          check(rx_bytes[1], m_count, $sformatf("row %0d status reply", idx));
        end
      end
      default: begin
      end
    endcase
  endtask

  ////////////////////
  // Main sequence
  ////////////////////

  initial begin
    clk = 1'b0;
    // Start high so reset sees a real falling edge
    arst_n = 1'b1;
    sck = 1'b0;
    mosi = 1'b0;
    ssel_n = 1'b1;
    lcg_state = 32'd12073;
    n_checks = 0;
    n_errors = 0;
    m_addr = '0;
    m_count = '0;
    build_table();
    #1;
    arst_n = 1'b0;
    repeat (4) @(posedge clk);
    #0.5;
    arst_n = 1'b1;
    wait_clks(4);
    check({7'd0, miso_oe}, 8'd0, "miso_oe after reset while deselected");
    for (int i = 0; i < tab_op.size(); i++) begin
      run_message(i);
      score_message(i);
    end
    check({7'd0, miso_oe}, 8'd0, "miso_oe deselected at end");
    $display("Checks run: %0d, errors: %0d", n_checks, n_errors);
    if (n_errors == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

  // Watchdog sized from the table
  initial begin : watchdog
    int unsigned limit_ns;
    #2;
    limit_ns = (tab_op.size() * MSG_CLKS + MARGIN) * CLK_NS;
    #(limit_ns);
    $display("Timeout: run did not finish within %0d ns", limit_ns);
    $display("CHECKS FAILED");
    $finish;
  end

endmodule

// File: list.f
hdl/spi_cmd_pkg.sv
hdl/spi_byte_if.sv
hdl/spi_slave.sv
hdl/mcu_cmd.sv
hdl/mem_addr_gen.sv
hdl/data_ram.sv
hdl/spi_mem_top.sv
testbench/tb_spi_mem_sva.sv
testbench/tb_spi_mem.sv

// File: run.sh
#!/bin/sh
# Build and run the SPI memory testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --assert -j 0 --top-module tb_spi_mem -f list.f

# Pass or fail is decided by the search below
out=$(./obj_dir/Vtb_spi_mem 2>&1) || true
echo "$out"

if echo "$out" | grep -qx "ALL CHECKS PASSED"; then
  exit 0
fi
exit 1
